// ==== logic/huff_pkg.sv ====
`default_nettype none

package huff_pkg;

    // ------------------------------------------------------------------------
    // Widths and depths
    // ------------------------------------------------------------------------
    localparam int CODE_W    = 16;
    localparam int LEN_COUNT = 16;
    localparam int LEN_W     = 4;
    localparam int PTR_W     = 10;
    localparam int SYM_DEPTH = 1024;
    localparam int SYM_W     = 8;

    typedef logic [CODE_W-1:0] code_t;
    typedef logic [PTR_W-1:0]  sym_ptr_t;
    typedef logic [SYM_W-1:0]  sym_t;

    // ------------------------------------------------------------------------
    // Table selects
    // ------------------------------------------------------------------------
    // Lookup side select
    typedef enum logic [1:0] {
        SEL_Y_DC = 2'd0,
        SEL_Y_AC = 2'd1,
        SEL_C_DC = 2'd2,
        SEL_C_AC = 2'd3
    } huff_sel_e;

    // Class and identifier byte as carried in the DHT segment
    typedef enum logic [7:0] {
        ID_Y_DC = 8'h00,
        ID_Y_AC = 8'h10,
        ID_C_DC = 8'h01,
        ID_C_AC = 8'h11
    } dht_id_e;

    // Per table, per code length
    typedef code_t    [3:0][LEN_COUNT-1:0] code_ranges_t;
    typedef sym_ptr_t [3:0][LEN_COUNT-1:0] ptr_ranges_t;

endpackage

`default_nettype wire

// ==== logic/huff_range_builder.sv ====
`default_nettype none

module huff_range_builder
    import huff_pkg::*;
(
    input  wire          clk_i,
    input  wire          rst_i,
    input  wire          cfg_valid_i,
    input  wire          cfg_last_i,
    input  sym_t         cfg_data_i,
    input  sym_ptr_t     wr_ptr_i,
    output logic         cfg_accept_o,
    output logic         sym_wr_o,
    output code_ranges_t min_code_o,
    output code_ranges_t max_code_o,
    output ptr_ranges_t  ptr_o
);

    typedef enum logic [1:0] {
        ST_ID,
        ST_COUNT,
        ST_SYMBOL
    } parse_state_e;

    parse_state_e state_q;
    dht_id_e      table_q;
    huff_sel_e    sel_w;

    // Byte index within the table, zero at the first count byte
    logic [11:0]          idx_q;
    sym_t                 count_q [LEN_COUNT];
    logic [LEN_COUNT-1:0] has_q;
    logic [11:0]          total_q;

    // Canonical code walk
    logic [LEN_W-1:0] len_q;
    sym_t             sym_idx_q;
    code_t            code_q;

    code_ranges_t min_q;
    code_ranges_t max_q;
    ptr_ranges_t  ptr_q;

    logic xfer_w;
    logic last_w;

    // ------------------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------------------
    // Stall only while stepping over an empty code length
    assign cfg_accept_o = (state_q != ST_SYMBOL) || has_q[len_q];
    assign xfer_w       = cfg_valid_i && cfg_accept_o;
    assign sym_wr_o     = xfer_w && (state_q == ST_SYMBOL);

    // Table ends on the flag or once all counted symbols have arrived
    assign last_w = cfg_last_i || ((state_q == ST_SYMBOL) && (idx_q == total_q));

    // Unknown identifiers land in chroma AC
    always_comb
    begin
        case (table_q)
            ID_Y_DC: sel_w = SEL_Y_DC;
            ID_Y_AC: sel_w = SEL_Y_AC;
            ID_C_DC: sel_w = SEL_C_DC;
            default: sel_w = SEL_C_AC;
        endcase
    end

    // ------------------------------------------------------------------------
    // Segment parser
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q <= ST_ID;
            table_q <= ID_Y_DC;
            idx_q   <= '0;
            has_q   <= '0;
            total_q <= 12'd15;
            for (int i = 0; i < LEN_COUNT; i++)
            begin
                count_q[i] <= '0;
            end
        end
        else if (xfer_w && last_w)
        begin
            state_q <= ST_ID;
            idx_q   <= '0;
            has_q   <= '0;
            total_q <= 12'd15;
            for (int i = 0; i < LEN_COUNT; i++)
            begin
                count_q[i] <= '0;
            end
        end
        else if (xfer_w)
        begin
            case (state_q)
                ST_ID:
                begin
                    table_q <= dht_id_e'(cfg_data_i);
                    idx_q   <= '0;
                    state_q <= ST_COUNT;
                end
                ST_COUNT:
                begin
                    count_q[idx_q[LEN_W-1:0]] <= cfg_data_i;
                    has_q[idx_q[LEN_W-1:0]]   <= (cfg_data_i != '0);
                    total_q                   <= total_q + {4'b0, cfg_data_i};
                    idx_q                     <= idx_q + 12'd1;
                    if (idx_q[LEN_W-1:0] == LEN_W'(LEN_COUNT - 1))
                    begin
                        state_q <= ST_SYMBOL;
                    end
                end
                default:
                begin
                    idx_q <= idx_q + 12'd1;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Canonical code walk and range tables
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            min_q     <= '0;
            max_q     <= '0;
            ptr_q     <= '0;
            len_q     <= '0;
            sym_idx_q <= '0;
            code_q    <= '0;
        end
        else if (state_q != ST_SYMBOL)
        begin
            len_q     <= '0;
            sym_idx_q <= '0;
            code_q    <= '0;
        end
        else if (xfer_w)
        begin
            // First symbol of this length opens its range
            if (sym_idx_q == '0)
            begin
                min_q[sel_w][len_q] <= code_q;
                max_q[sel_w][len_q] <= code_q + code_t'(count_q[len_q]);
                ptr_q[sel_w][len_q] <= wr_ptr_i;
            end

            if ((sym_idx_q + 8'd1) == count_q[len_q])
            begin
                sym_idx_q <= '0;
                len_q     <= len_q + 1'b1;
                code_q    <= (code_q + 16'd1) << 1;
            end
            else
            begin
                sym_idx_q <= sym_idx_q + 8'd1;
                code_q    <= code_q + 16'd1;
            end
        end
        else if (cfg_valid_i)
        begin
            // Empty length, one per cycle
            len_q  <= len_q + 1'b1;
            code_q <= code_q << 1;
        end
    end

    assign min_code_o = min_q;
    assign max_code_o = max_q;
    assign ptr_o      = ptr_q;

endmodule

`default_nettype wire

// ==== logic/huff_symbol_store.sv ====
`default_nettype none

module huff_symbol_store
    import huff_pkg::*;
(
    input  wire      clk_i,
    input  wire      rst_i,
    input  wire      sym_wr_i,
    input  sym_t     wr_data_i,
    input  sym_ptr_t rd_addr_i,
    output sym_ptr_t wr_ptr_o,
    output sym_t     rd_data_o
);

    sym_t     mem_q [SYM_DEPTH];
    sym_ptr_t wr_ptr_q;
    sym_t     rd_data_q;

    // ------------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------------
    // Pointer runs across every table in every segment
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            wr_ptr_q <= '0;
        end
        else if (sym_wr_i)
        begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (sym_wr_i)
        begin
            mem_q[wr_ptr_q] <= wr_data_i;
        end
    end

    // ------------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        rd_data_q <= mem_q[rd_addr_i];
    end

    assign wr_ptr_o  = wr_ptr_q;
    assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

// ==== logic/huff_lookup.sv ====
`default_nettype none

module huff_lookup
    import huff_pkg::*;
(
    input  wire              clk_i,
    input  wire              rst_i,
    input  wire              lookup_req_i,
    input  huff_sel_e        lookup_table_i,
    input  code_t            lookup_input_i,
    input  code_ranges_t     min_code_i,
    input  code_ranges_t     max_code_i,
    input  ptr_ranges_t      ptr_i,
    output sym_ptr_t         rd_addr_o,
    output logic             lookup_valid_o,
    output logic [LEN_W:0]   lookup_width_o
);

    logic [LEN_W-1:0] match_len;

    // Stage 1 registers
    logic             req_q;
    logic [LEN_W-1:0] len_q;
    huff_sel_e        table_q;
    code_t            window_q;

    // Stage 2
    code_t            aligned_w;
    code_t            addr_w;
    sym_ptr_t         rd_addr_q;
    logic [LEN_W-1:0] addr_len_q;
    logic             addr_valid_q;

    // Output stage, in step with the store read
    logic             valid_q;
    logic [LEN_W:0]   width_q;

    // ------------------------------------------------------------------------
    // Stage 1 finds the shortest matching length
    // ------------------------------------------------------------------------
    // Lengths 1 to 15 are searched and a miss is taken as 16
    always_comb
    begin
        match_len = LEN_W'(LEN_COUNT - 1);
        for (int k = LEN_COUNT - 2; k >= 0; k--)
        begin
            if ((lookup_input_i >> (CODE_W - 1 - k)) < max_code_i[lookup_table_i][k])
            begin
                match_len = LEN_W'(k);
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        len_q    <= match_len;
        table_q  <= lookup_table_i;
        window_q <= lookup_input_i;
    end

    // ------------------------------------------------------------------------
    // Stage 2 forms the symbol address
    // ------------------------------------------------------------------------
    // Code offset within its length plus the base slot of that length
    always_comb
    begin
        aligned_w = window_q >> (CODE_W - 1 - len_q);
        addr_w    = aligned_w - min_code_i[table_q][len_q]
                    + code_t'(ptr_i[table_q][len_q]);
    end

    always_ff @(posedge clk_i)
    begin
        rd_addr_q  <= addr_w[PTR_W-1:0];
        addr_len_q <= len_q;
    end

    assign rd_addr_o = rd_addr_q;

    // Width lines up with the registered store read
    always_ff @(posedge clk_i)
    begin
        width_q <= {1'b0, addr_len_q} + 1'b1;
    end

    // Valid follows the address register and then the store read
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            req_q        <= 1'b0;
            addr_valid_q <= 1'b0;
            valid_q      <= 1'b0;
        end
        else
        begin
            req_q        <= lookup_req_i;
            addr_valid_q <= req_q;
            valid_q      <= addr_valid_q;
        end
    end

    assign lookup_valid_o = valid_q;
    assign lookup_width_o = width_q;

endmodule

`default_nettype wire

// ==== logic/jpeg_huff_table.sv ====
`default_nettype none

module jpeg_huff_table
    import huff_pkg::*;
(
    input  wire            clk_i,
    input  wire            rst_i,

    // Configuration byte stream
    input  wire            cfg_valid_i,
    input  sym_t           cfg_data_i,
    input  wire            cfg_last_i,
    output logic           cfg_accept_o,

    // Lookup
    input  wire            lookup_req_i,
    input  huff_sel_e      lookup_table_i,
    input  code_t          lookup_input_i,
    output logic           lookup_valid_o,
    output logic [LEN_W:0] lookup_width_o,
    output sym_t           lookup_value_o
);

    logic         sym_wr;
    sym_ptr_t     wr_ptr;
    sym_ptr_t     rd_addr;
    code_ranges_t min_code;
    code_ranges_t max_code;
    ptr_ranges_t  ptr;

    // ------------------------------------------------------------------------
    // DHT parse and range build
    // ------------------------------------------------------------------------
    huff_range_builder u_builder (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cfg_valid_i  (cfg_valid_i),
        .cfg_last_i   (cfg_last_i),
        .cfg_data_i   (cfg_data_i),
        .wr_ptr_i     (wr_ptr),
        .cfg_accept_o (cfg_accept_o),
        .sym_wr_o     (sym_wr),
        .min_code_o   (min_code),
        .max_code_o   (max_code),
        .ptr_o        (ptr)
    );

    // Symbol bytes go straight from the stream into the store
    huff_symbol_store u_store (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .sym_wr_i  (sym_wr),
        .wr_data_i (cfg_data_i),
        .rd_addr_i (rd_addr),
        .wr_ptr_o  (wr_ptr),
        .rd_data_o (lookup_value_o)
    );

    // ------------------------------------------------------------------------
    // Code match
    // ------------------------------------------------------------------------
    huff_lookup u_lookup (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .lookup_req_i   (lookup_req_i),
        .lookup_table_i (lookup_table_i),
        .lookup_input_i (lookup_input_i),
        .min_code_i     (min_code),
        .max_code_i     (max_code),
        .ptr_i          (ptr),
        .rd_addr_o      (rd_addr),
        .lookup_valid_o (lookup_valid_o),
        .lookup_width_o (lookup_width_o)
    );

endmodule

`default_nettype wire

// ==== bench/huff_tb_tasks.svh ====
`ifndef HUFF_TB_TASKS_SVH
`define HUFF_TB_TASKS_SVH

// Count bytes with length 1 in the top byte
localparam logic [127:0] Y_DC_COUNTS = 128'h0001_0501_0101_0101_0100_0000_0000_0000;
localparam logic [127:0] Y_AC_COUNTS = 128'h0002_0103_0302_0403_0505_0404_0000_017d;
localparam logic [127:0] C_DC_COUNTS = 128'h0003_0101_0101_0101_0101_0100_0000_0000;
localparam logic [127:0] GAP_COUNTS  = 128'h0001_0000_0200_0000_0300_0001_0000_0000;

// Reference model indexed by table select
int   ref_count [4][LEN_COUNT];
int   ref_total [4];
int   slot_base [4];
int   next_slot    = 0;
int   stall_cycles = 0;
sym_t shadow_mem [SYM_DEPTH];

// ----------------------------------------------------------------------------
// Configuration stream
// ----------------------------------------------------------------------------
task automatic send_byte(input sym_t data, input logic last);
    int cycles;
    cycles    = 0;
    cfg_valid = 1'b1;
    cfg_data  = data;
    cfg_last  = last;
    while (!cfg_accept && cycles < CFG_TIMEOUT)
    begin
        @(posedge clk);
        #1;
        cycles++;
        stall_cycles++;
    end
    if (!cfg_accept)
    begin
        $display("Timeout: configuration byte %h was never accepted", data);
        n_errors++;
        finish_run();
    end
    else
    begin
        @(posedge clk);
        #1;
        cfg_valid = 1'b0;
        cfg_last  = 1'b0;
    end
endtask

// Symbols follow base plus rank times step
task automatic load_table(input dht_id_e id, input int sel, input logic [127:0] counts,
                          input sym_t sym_base, input sym_t sym_step, input logic last);
    int   total;
    sym_t sym;
    total = 0;
    send_byte(sym_t'(id), 1'b0);
    for (int i = 0; i < LEN_COUNT; i++)
    begin
        ref_count[sel][i] = int'(counts[127 - 8*i -: 8]);
        total += ref_count[sel][i];
        send_byte(sym_t'(ref_count[sel][i]), 1'b0);
    end
    ref_total[sel] = total;
    slot_base[sel] = next_slot;
    for (int i = 0; i < total; i++)
    begin
        sym = sym_base + sym_t'(i) * sym_step;
        shadow_mem[next_slot % SYM_DEPTH] = sym;
        next_slot++;
        send_byte(sym, last && (i == total - 1));
    end
endtask

// ----------------------------------------------------------------------------
// Canonical code model and lookups
// ----------------------------------------------------------------------------
task automatic find_code(input int sel, input int rank, output int len, output int code);
    int r;
    int c;
    r    = 0;
    c    = 0;
    len  = 0;
    code = 0;
    for (int l = 1; l <= LEN_COUNT; l++)
    begin
        for (int j = 0; j < ref_count[sel][l-1]; j++)
        begin
            if (r == rank)
            begin
                len  = l;
                code = c;
            end
            r++;
            c++;
        end
        c = c << 1;
    end
endtask

// Code in the top bits with random bits below it
task automatic prepare_lookup(input int sel, input int rank, output code_t window,
                              output int len, output int sym);
    int code;
    find_code(sel, rank, len, code);
    window = code_t'(code << (CODE_W - len)) | random_filler(CODE_W - len);
    sym    = shadow_mem[(slot_base[sel] + rank) % SYM_DEPTH];
endtask

task automatic lookup_check(input int sel, input int rank);
    code_t window;
    int    len;
    int    sym;
    int    cycles;
    prepare_lookup(sel, rank, window, len, sym);
    lookup_req   = 1'b1;
    lookup_table = huff_sel_e'(sel);
    lookup_input = window;
    @(posedge clk);
    #1;
    lookup_req = 1'b0;
    cycles     = 0;
    while (!lookup_valid && cycles < LOOKUP_TIMEOUT)
    begin
        @(posedge clk);
        #1;
        cycles++;
    end
    if (!lookup_valid)
    begin
        $display("Timeout: no lookup result for table %0d rank %0d", sel, rank);
        n_errors++;
        finish_run();
    end
    else
    begin
        check_value($sformatf("table %0d rank %0d width", sel, rank), lookup_width, len);
        check_value($sformatf("table %0d rank %0d symbol", sel, rank), lookup_value, sym);
    end
endtask

task automatic check_table(input int sel);
    for (int r = 0; r < ref_total[sel]; r++)
    begin
        lookup_check(sel, r);
    end
endtask

// ----------------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------------
task automatic idle_after_reset();
    for (int i = 0; i < 10; i++)
    begin
        check_value("lookup_valid_o after reset", lookup_valid, 0);
        check_value("cfg_accept_o after reset", cfg_accept, 1);
        @(posedge clk);
        #1;
    end
endtask

task automatic single_luma_dc_table();
    load_table(ID_Y_DC, SEL_Y_DC, Y_DC_COUNTS, 8'h00, 8'h01, 1'b1);
    check_table(SEL_Y_DC);
endtask

// First table ends on its count and the second on the flag
task automatic two_tables_in_one_segment();
    load_table(ID_Y_AC, SEL_Y_AC, Y_AC_COUNTS, 8'h01, 8'h07, 1'b0);
    load_table(ID_C_DC, SEL_C_DC, C_DC_COUNTS, 8'h80, 8'h03, 1'b1);
    check_table(SEL_Y_AC);
    check_table(SEL_C_DC);
    check_table(SEL_Y_DC);
endtask

// One request per cycle with each result two edges after it
task automatic alternating_back_to_back();
    code_t window  [12];
    int    sel     [12];
    int    exp_len [12];
    int    exp_sym [12];
    for (int k = 0; k < 12; k++)
    begin
        sel[k] = (k % 2 == 0) ? SEL_Y_DC : SEL_C_DC;
        prepare_lookup(sel[k], k / 2, window[k], exp_len[k], exp_sym[k]);
    end
    for (int k = 0; k < 14; k++)
    begin
        lookup_req = (k < 12);
        if (k < 12)
        begin
            lookup_table = huff_sel_e'(sel[k]);
            lookup_input = window[k];
        end
        @(posedge clk);
        #1;
        if (k >= 2)
        begin
            check_value($sformatf("burst %0d valid", k - 2), lookup_valid, 1);
            check_value($sformatf("burst %0d width", k - 2), lookup_width, exp_len[k-2]);
            check_value($sformatf("burst %0d symbol", k - 2), lookup_value, exp_sym[k-2]);
        end
        else
        begin
            check_value("valid before first burst result", lookup_valid, 0);
        end
    end
    lookup_req = 1'b0;
    @(posedge clk);
    #1;
    check_value("lookup_valid_o after the burst", lookup_valid, 0);
endtask

// One stall per empty length below the longest used one
task automatic table_with_gaps();
    int highest;
    int expected;
    highest      = 0;
    expected     = 0;
    stall_cycles = 0;
    load_table(ID_C_AC, SEL_C_AC, GAP_COUNTS, 8'h40, 8'h03, 1'b1);
    for (int i = 0; i < LEN_COUNT; i++)
    begin
        if (ref_count[SEL_C_AC][i] != 0)
        begin
            highest = i;
        end
    end
    for (int i = 0; i < highest; i++)
    begin
        if (ref_count[SEL_C_AC][i] == 0)
        begin
            expected++;
        end
    end
    check_value("stall cycles over empty lengths", stall_cycles, expected);
    check_table(SEL_C_AC);
endtask

// Same lengths with new symbols at the advanced pointer
task automatic reload_chroma_ac();
    load_table(ID_C_AC, SEL_C_AC, GAP_COUNTS, 8'ha0, 8'h05, 1'b1);
    check_table(SEL_C_AC);
    check_table(SEL_Y_DC);
endtask

`endif

// ==== bench/huff_tb.sv ====
`default_nettype none

module huff_tb
    import huff_pkg::*;
();

    localparam int CFG_TIMEOUT    = 64;
    localparam int LOOKUP_TIMEOUT = 8;

    logic           clk;
    logic           rst;
    logic           cfg_valid;
    sym_t           cfg_data;
    logic           cfg_last;
    logic           cfg_accept;
    logic           lookup_req;
    huff_sel_e      lookup_table;
    code_t          lookup_input;
    logic           lookup_valid;
    logic [LEN_W:0] lookup_width;
    sym_t           lookup_value;

    int          n_checks;
    int          n_errors;
    logic [31:0] lfsr;

    jpeg_huff_table dut (
        .clk_i          (clk),
        .rst_i          (rst),
        .cfg_valid_i    (cfg_valid),
        .cfg_data_i     (cfg_data),
        .cfg_last_i     (cfg_last),
        .cfg_accept_o   (cfg_accept),
        .lookup_req_i   (lookup_req),
        .lookup_table_i (lookup_table),
        .lookup_input_i (lookup_input),
        .lookup_valid_o (lookup_valid),
        .lookup_width_o (lookup_width),
        .lookup_value_o (lookup_value)
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------------------
    // Random filler bits
    // ------------------------------------------------------------------------
    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic next_random_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic code_t random_filler(input int n);
        code_t bits;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            bits = {bits[CODE_W-2:0], next_random_bit()};
        end
        return bits;
    endfunction

    // ------------------------------------------------------------------------
    // Checking and end of run
    // ------------------------------------------------------------------------
    task automatic check_value(input string what, input int got, input int exp);
        n_checks++;
        assert (got == exp)
        else
        begin
            n_errors++;
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    initial
    begin
        clk          = 1'b0;
        rst          = 1'b1;
        cfg_valid    = 1'b0;
        cfg_data     = '0;
        cfg_last     = 1'b0;
        lookup_req   = 1'b0;
        lookup_table = SEL_Y_DC;
        lookup_input = '0;
        n_checks     = 0;
        n_errors     = 0;
        lfsr         = 32'hb711_a2ee;

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        idle_after_reset();
        single_luma_dc_table();
        two_tables_in_one_segment();
        alternating_back_to_back();
        table_with_gaps();
        reload_chroma_ac();
        finish_run();
    end

`include "huff_tb_tasks.svh"

endmodule

`default_nettype wire

// ==== jpeg_huff_table.f ====
+incdir+bench
logic/huff_pkg.sv
logic/huff_range_builder.sv
logic/huff_symbol_store.sv
logic/huff_lookup.sv
logic/jpeg_huff_table.sv
bench/huff_tb.sv

// ==== Bender.yml ====
package:
  name: jpeg_huff_table

sources:
  - files:
      - logic/huff_pkg.sv
      - logic/huff_range_builder.sv
      - logic/huff_symbol_store.sv
      - logic/huff_lookup.sv
      - logic/jpeg_huff_table.sv

  - target: test
    include_dirs:
      - bench
    files:
      - bench/huff_tb.sv
